/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // instruction TLB geometry
    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = $clog2(tlb_num);

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // fetch exception vector
    localparam int fs_exc_w = 4;
    localparam int exc_adef = 0;    // bad fetch address
    localparam int exc_tlbr = 1;    // tlb refill, no matching entry
    localparam int exc_pif  = 2;    // page invalid on fetch
    localparam int exc_ppi  = 3;    // page privilege violation

    // page size codes, log2 of the page size in bytes
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_4m = 6'd22;

    // least privileged level
    localparam logic [1:0] plv_user = 2'd3;

endpackage

/* verilog/itlb.sv */
`timescale 1ns/100ps

module itlb import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    // write port
    input  logic                 tlb_we,
    input  logic [tlb_idx_w-1:0] tlb_w_index,
    input  logic                 tlb_w_e,
    input  logic [19:0]          tlb_w_vppn,
    input  logic [5:0]           tlb_w_ps,
    input  logic [19:0]          tlb_w_ppn,
    input  logic [1:0]           tlb_w_plv,
    input  logic                 tlb_w_v,
    // lookup port
    input  logic [19:0]          s0_vppn,
    output logic                 s0_found,
    output logic [19:0]          s0_ppn,
    output logic [5:0]           s0_ps,
    output logic [1:0]           s0_plv,
    output logic                 s0_v
);

    logic [tlb_num-1:0] tlb_e;     // entry exists
    logic [19:0]        tlb_vppn [tlb_num];
    logic [5:0]         tlb_ps   [tlb_num];
    logic [19:0]        tlb_ppn  [tlb_num];
    logic [1:0]         tlb_plv  [tlb_num];
    logic [tlb_num-1:0] tlb_v;
    logic [tlb_num-1:0] match;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tlb_e <= '0;
        end else if (tlb_we) begin
            tlb_e[tlb_w_index] <= tlb_w_e;
        end
    end

    // entry contents, only meaningful while e is set
    always_ff @(posedge clk) begin
        if (tlb_we) begin
            tlb_vppn[tlb_w_index] <= tlb_w_vppn;
            tlb_ps[tlb_w_index]   <= tlb_w_ps;
            tlb_ppn[tlb_w_index]  <= tlb_w_ppn;
            tlb_plv[tlb_w_index]  <= tlb_w_plv;
            tlb_v[tlb_w_index]    <= tlb_w_v;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            if (tlb_ps[i] == ps_4m)
                match[i] = tlb_e[i] && (tlb_vppn[i][19:10] == s0_vppn[19:10]);
            else
                match[i] = tlb_e[i] && (tlb_vppn[i] == s0_vppn);
        end
    end

    // match is one-hot when the entries are programmed sanely
    always_comb begin
        s0_ppn = '0;
        s0_ps  = '0;
        s0_plv = '0;
        s0_v   = 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            if (match[i]) begin
                s0_ppn = tlb_ppn[i];
                s0_ps  = tlb_ps[i];
                s0_plv = tlb_plv[i];
                s0_v   = tlb_v[i];
            end
        end
    end

    assign s0_found = |match;

    // overlapping pages would make the returned fields a mix of entries
    a_single_match: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(match));

endmodule

/* verilog/addr_translate.sv */
`timescale 1ns/100ps

module addr_translate import fetch_pkg::*; (
    input  logic [31:0]         nextpc,
    input  logic [1:0]          crmd_plv,
    input  logic                csr_direct_addr,
    input  logic                dmw0_plv0,
    input  logic                dmw0_plv3,
    input  logic [2:0]          dmw0_vseg,
    input  logic [2:0]          dmw0_pseg,
    input  logic                dmw1_plv0,
    input  logic                dmw1_plv3,
    input  logic [2:0]          dmw1_vseg,
    input  logic [2:0]          dmw1_pseg,
    output logic [19:0]         s0_vppn,
    input  logic                s0_found,
    input  logic [19:0]         s0_ppn,
    input  logic [5:0]          s0_ps,
    input  logic [1:0]          s0_plv,
    input  logic                s0_v,
    output logic [31:0]         paddr,
    output logic [fs_exc_w-1:0] req_exc
);

    logic        plv_kern;
    logic        plv_usr;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_used;
    logic [31:0] tlb_paddr;

    assign plv_kern = (crmd_plv == 2'd0);
    assign plv_usr  = (crmd_plv == plv_user);

    // windows only apply in mapped mode
    assign dmw0_hit = ~csr_direct_addr && (nextpc[31:29] == dmw0_vseg) &&
                      (plv_kern && dmw0_plv0 || plv_usr && dmw0_plv3);
    assign dmw1_hit = ~csr_direct_addr && (nextpc[31:29] == dmw1_vseg) &&
                      (plv_kern && dmw1_plv0 || plv_usr && dmw1_plv3);

    assign tlb_used = ~csr_direct_addr & ~dmw0_hit & ~dmw1_hit;
    assign s0_vppn  = nextpc[31:12];

    assign tlb_paddr = (s0_ps == ps_4k) ? {s0_ppn, nextpc[11:0]}
                                        : {s0_ppn[19:10], nextpc[21:0]};   // 4M page

    always_comb begin
        if (csr_direct_addr)
            paddr = nextpc;
        else if (dmw0_hit)
            paddr = {dmw0_pseg, nextpc[28:0]};
        else if (dmw1_hit)
            paddr = {dmw1_pseg, nextpc[28:0]};
        else
            paddr = tlb_paddr;
    end

    assign req_exc[exc_adef] = ((|nextpc[1:0]) | (nextpc[31] & plv_usr)) & ~dmw0_hit & ~dmw1_hit;
    assign req_exc[exc_tlbr] = tlb_used & ~s0_found;
    assign req_exc[exc_pif]  = tlb_used & s0_found & ~s0_v;
    assign req_exc[exc_ppi]  = tlb_used & s0_found & s0_v & (crmd_plv > s0_plv);

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import fetch_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    // instruction sram
    output logic                inst_sram_req,
    input  logic                inst_sram_addr_ok,
    input  logic                inst_sram_data_ok,
    input  logic [31:0]         inst_sram_rdata,
    // redirects and decode side
    input  logic                ds_allowin,
    input  logic                br_stall,
    input  logic                br_taken,
    input  logic [31:0]         br_target,
    input  logic                wb_ex,
    input  logic [31:0]         ex_entry,
    input  logic                ertn_flush,
    input  logic [31:0]         ertn_entry,
    // translation
    output logic [31:0]         nextpc,
    input  logic [fs_exc_w-1:0] req_exc,
    // to decode
    output logic                fs2ds_valid,
    output logic [31:0]         fs2ds_pc,
    output logic [31:0]         fs2ds_inst,
    output logic [fs_exc_w-1:0] fs2ds_exc
);

    logic                run;          // out of reset
    logic                outstanding;  // request accepted, data pending
    logic                discard;      // pending data is stale
    logic                buf_valid;
    logic [31:0]         inst_buf;
    logic [31:0]         fs_pc;
    logic [fs_exc_w-1:0] fs_exc;

    logic                wb_ex_r;
    logic                ertn_flush_r;
    logic                br_taken_r;
    logic [31:0]         ex_entry_r;
    logic [31:0]         ertn_entry_r;
    logic [31:0]         br_target_r;

    logic                cancel;
    logic                ex_redirect;
    logic                accept;
    logic                resp;
    logic                ds_hold;
    logic [31:0]         seq_pc;

    assign cancel      = wb_ex | ertn_flush | br_taken;
    assign ex_redirect = wb_ex | wb_ex_r | ertn_flush | ertn_flush_r;
    assign seq_pc      = fs_pc + 32'd4;

    // held redirects first, they are older than any new strobe
    always_comb begin
        if (wb_ex_r)           nextpc = ex_entry_r;
        else if (wb_ex)        nextpc = ex_entry;
        else if (ertn_flush_r) nextpc = ertn_entry_r;
        else if (ertn_flush)   nextpc = ertn_entry;
        else if (br_taken_r)   nextpc = br_target_r;
        else if (br_taken)     nextpc = br_target;
        else                   nextpc = seq_pc;
    end

    assign resp    = inst_sram_data_ok & outstanding & ~discard;  // live response
    assign ds_hold = buf_valid & ~ds_allowin;

    // exceptions may fetch past an unresolved branch
    assign inst_sram_req = run & ~outstanding & ~ds_hold & (~br_stall | ex_redirect);
    assign accept        = inst_sram_req & inst_sram_addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn)
            run <= 1'b0;
        else
            run <= 1'b1;
    end

    // redirect flags drop once their target is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ex_r      <= 1'b0;
            ertn_flush_r <= 1'b0;
            br_taken_r   <= 1'b0;
        end else if (accept) begin
            wb_ex_r      <= 1'b0;
            ertn_flush_r <= 1'b0;
            br_taken_r   <= 1'b0;
        end else begin
            if (wb_ex)      wb_ex_r      <= 1'b1;
            if (ertn_flush) ertn_flush_r <= 1'b1;
            if (br_taken)   br_taken_r   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex)      ex_entry_r   <= ex_entry;
        if (ertn_flush) ertn_entry_r <= ertn_entry;
        if (br_taken)   br_target_r  <= br_target;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            outstanding <= 1'b0;
        else if (accept)
            outstanding <= 1'b1;
        else if (inst_sram_data_ok)
            outstanding <= 1'b0;
    end

    // a cancel in the data_ok cycle is handled by gating fs2ds_valid
    always_ff @(posedge clk) begin
        if (!resetn)
            discard <= 1'b0;
        else if (cancel & outstanding & ~inst_sram_data_ok)
            discard <= 1'b1;
        else if (inst_sram_data_ok)
            discard <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            buf_valid <= 1'b0;
        else if (cancel | buf_valid & ds_allowin)
            buf_valid <= 1'b0;
        else if (resp & ~ds_allowin)
            buf_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (resp & ~buf_valid)
            inst_buf <= inst_sram_rdata;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            fs_pc <= reset_pc - 32'd4;
        else if (accept)
            fs_pc <= nextpc;
    end

    always_ff @(posedge clk) begin
        if (accept)
            fs_exc <= req_exc;
    end

    assign fs2ds_valid = (resp | buf_valid) & ~cancel;
    assign fs2ds_pc    = fs_pc;
    assign fs2ds_inst  = buf_valid ? inst_buf : inst_sram_rdata;
    assign fs2ds_exc   = fs_exc;

    // one request in flight: nothing new until its data returns
    a_one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_req && inst_sram_addr_ok |=> !inst_sram_req);

    // a held instruction must not change under the decoder
    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        fs2ds_valid && !ds_allowin |=> $stable(fs2ds_pc) && $stable(fs2ds_inst));

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    output logic                 inst_sram_req,
    output logic [31:0]          inst_sram_addr,
    input  logic                 inst_sram_addr_ok,
    input  logic                 inst_sram_data_ok,
    input  logic [31:0]          inst_sram_rdata,
    output logic                 fs2ds_valid,
    output logic [31:0]          fs2ds_pc,
    output logic [31:0]          fs2ds_inst,
    output logic [fs_exc_w-1:0]  fs2ds_exc,
    input  logic                 ds_allowin,
    input  logic                 wb_ex,
    input  logic [31:0]          ex_entry,
    input  logic                 ertn_flush,
    input  logic [31:0]          ertn_entry,
    input  logic                 br_taken,
    input  logic [31:0]          br_target,
    input  logic                 br_stall,
    input  logic [1:0]           crmd_plv,
    input  logic                 csr_direct_addr,
    input  logic                 dmw0_plv0,
    input  logic                 dmw0_plv3,
    input  logic [2:0]           dmw0_vseg,
    input  logic [2:0]           dmw0_pseg,
    input  logic                 dmw1_plv0,
    input  logic                 dmw1_plv3,
    input  logic [2:0]           dmw1_vseg,
    input  logic [2:0]           dmw1_pseg,
    input  logic                 tlb_we,
    input  logic [tlb_idx_w-1:0] tlb_w_index,
    input  logic                 tlb_w_e,
    input  logic [19:0]          tlb_w_vppn,
    input  logic [5:0]           tlb_w_ps,
    input  logic [19:0]          tlb_w_ppn,
    input  logic [1:0]           tlb_w_plv,
    input  logic                 tlb_w_v
);

    logic [31:0]         nextpc;     // virtual fetch address
    logic [fs_exc_w-1:0] req_exc;
    logic [19:0]         s0_vppn;
    logic                s0_found;
    logic [19:0]         s0_ppn;
    logic [5:0]          s0_ps;
    logic [1:0]          s0_plv;
    logic                s0_v;

    fetch_stage fetch_stage_inst (.*);

    // physical address goes straight out to the sram
    addr_translate addr_translate_inst (
        .paddr (inst_sram_addr),
        .*
    );

    itlb itlb_inst (.*);

endmodule

/* tb/inst_sram_model.sv */
`timescale 1ns/100ps

module inst_sram_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    int          seed = 79;
    int          addr_wait;             // req cycles left before addr_ok
    int          data_wait;             // cycles left before data_ok
    logic        busy;                  // accepted, data not returned yet
    logic [31:0] addr_q;
    logic        addr_ok_r = 1'b0;
    logic        data_ok_r = 1'b0;
    logic [31:0] rdata_r   = '0;

    always @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            addr_wait <= 0;
            data_wait <= 0;
        end else if (req && addr_ok) begin
            busy      <= 1'b1;
            addr_q    <= addr;
            data_wait <= $unsigned($random(seed)) % 3;   // data 1 to 3 cycles later
            addr_wait <= $unsigned($random(seed)) % 3;   // delay for the next request
        end else if (busy) begin
            if (data_wait == 0)
                busy <= 1'b0;
            else
                data_wait <= data_wait - 1;
        end else if (req && addr_wait > 0) begin
            addr_wait <= addr_wait - 1;
        end
    end

    // outputs change on the falling edge only
    always @(negedge clk) begin
        addr_ok_r <= resetn && !busy && addr_wait == 0;
        data_ok_r <= resetn && busy && data_wait == 0;
        rdata_r   <= ~addr_q;       // inverse of the physical address
    end

    assign addr_ok = addr_ok_r;
    assign data_ok = data_ok_r;
    assign rdata   = rdata_r;

endmodule

/* tb/tb_fetch_unit.sv */
`timescale 1ns/100ps

module tb_fetch_unit import fetch_pkg::*; ();

    logic                 clk;
    logic                 resetn;
    logic                 inst_sram_req;
    logic [31:0]          inst_sram_addr;
    logic                 inst_sram_addr_ok;
    logic                 inst_sram_data_ok;
    logic [31:0]          inst_sram_rdata;
    logic                 fs2ds_valid;
    logic [31:0]          fs2ds_pc;
    logic [31:0]          fs2ds_inst;
    logic [fs_exc_w-1:0]  fs2ds_exc;
    logic                 ds_allowin;
    logic                 wb_ex, ertn_flush, br_taken, br_stall;
    logic [31:0]          ex_entry, ertn_entry, br_target;
    logic [1:0]           crmd_plv;
    logic                 csr_direct_addr;
    logic                 dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3;
    logic [2:0]           dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic                 tlb_we, tlb_w_e, tlb_w_v;
    logic [tlb_idx_w-1:0] tlb_w_index;
    logic [19:0]          tlb_w_vppn, tlb_w_ppn;
    logic [5:0]           tlb_w_ps;
    logic [1:0]           tlb_w_plv;

    int                   errors;
    int                   checks;
    bit                   timed_out;
    logic [31:0]          exp_pc;       // pc of the next instruction in sequence
    logic [31:0]          got_pc;
    logic [31:0]          got_inst;
    logic [fs_exc_w-1:0]  got_exc;

    fetch_unit fetch_unit_inst (.*);

    inst_sram_model inst_sram_model_inst (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [fs_exc_w-1:0] exc_bit(input int pos);
        logic [fs_exc_w-1:0] e;
        e      = '0;
        e[pos] = 1'b1;
        return e;
    endfunction

    // physical address of va inside a page of the given size
    function automatic logic [31:0] page_addr(input logic [31:0] va, input logic [19:0] ppn,
                                              input logic [5:0] ps);
        if (ps == ps_4m)
            return {ppn[19:10], va[21:0]};
        return {ppn, va[11:0]};
    endfunction

    // tasks start and end just after a falling edge, sampling happens 1 ns before the rise
    task automatic take_inst();
        int n;
        bit got;
        n   = 0;
        got = 1'b0;
        while (!got && !timed_out) begin
            #4;
            if (fs2ds_valid && ds_allowin) begin
                got_pc   = fs2ds_pc;
                got_inst = fs2ds_inst;
                got_exc  = fs2ds_exc;
                got      = 1'b1;
            end
            @(negedge clk);
            n++;
            if (!got && n >= 50) begin
                $display("timeout: no instruction reached decode within 50 cycles");
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic expect_inst(input logic [31:0] pc, input logic [31:0] pa,
                               input logic [fs_exc_w-1:0] exc);
        take_inst();
        if (!timed_out) begin
            check("pc", got_pc, pc);
            check("inst", got_inst, ~pa);
            check("exc", 32'(got_exc), 32'(exc));
        end
    endtask

    task automatic redirect(input bit ex, input logic [31:0] ex_pc,
                            input bit br, input logic [31:0] br_pc);
        wb_ex     = ex;
        ex_entry  = ex_pc;
        br_taken  = br;
        br_target = br_pc;
        #4;
        check("transfer in redirect cycle", 32'(fs2ds_valid && ds_allowin), 32'd0);
        @(negedge clk);
        wb_ex    = 1'b0;
        br_taken = 1'b0;
    endtask

    // redirect to pc, the fetch there must carry exactly these exception bits
    task automatic expect_fault(input logic [31:0] pc, input logic [fs_exc_w-1:0] exc);
        redirect(1'b0, 32'h0, 1'b1, pc);
        take_inst();
        if (!timed_out) begin
            check("fault pc", got_pc, pc);
            check("fault exc", 32'(got_exc), 32'(exc));
        end
    endtask

    task automatic write_tlb(input int idx, input logic [19:0] vppn, input logic [5:0] ps,
                             input logic [19:0] ppn, input logic [1:0] plv, input bit v);
        tlb_we      = 1'b1;
        tlb_w_index = idx[tlb_idx_w-1:0];
        tlb_w_e     = 1'b1;
        tlb_w_vppn  = vppn;
        tlb_w_ps    = ps;
        tlb_w_ppn   = ppn;
        tlb_w_plv   = plv;
        tlb_w_v     = v;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    task automatic test_sequential();
        exp_pc = reset_pc;
        repeat (6) begin
            expect_inst(exp_pc, exp_pc, '0);    // direct mode, pa equals va
            exp_pc += 4;
        end
    endtask

    task automatic test_backpressure();
        int          n;
        logic [31:0] held_pc;
        logic [31:0] held_inst;
        ds_allowin = 1'b0;
        n          = 0;
        #4;
        while (!fs2ds_valid && n < 50) begin
            @(negedge clk);
            #4;
            n++;
        end
        if (!fs2ds_valid) begin
            $display("timeout: no instruction was offered while decode held back");
            errors++;
            timed_out = 1'b1;
        end
        held_pc   = fs2ds_pc;
        held_inst = fs2ds_inst;
        check("held pc", held_pc, exp_pc);
        check("held inst", held_inst, ~exp_pc);
        repeat (6) begin
            @(negedge clk);
            #4;
            check("valid while held", 32'(fs2ds_valid), 32'd1);
            check("pc while held", fs2ds_pc, held_pc);
            check("inst while held", fs2ds_inst, held_inst);
        end
        @(negedge clk);
        ds_allowin = 1'b1;
        repeat (4) begin
            expect_inst(exp_pc, exp_pc, '0);
            exp_pc += 4;
        end
    endtask

    task automatic test_redirect();
        redirect(1'b0, 32'h0, 1'b1, 32'h1c00_1000);
        exp_pc = 32'h1c00_1000;
        repeat (3) begin
            expect_inst(exp_pc, exp_pc, '0);
            exp_pc += 4;
        end
        // redirect while an instruction sits in the buffer
        ds_allowin = 1'b0;
        repeat (5) @(negedge clk);
        redirect(1'b0, 32'h0, 1'b1, 32'h1c00_4000);
        ds_allowin = 1'b1;
        exp_pc     = 32'h1c00_4000;
        repeat (2) begin
            expect_inst(exp_pc, exp_pc, '0);
            exp_pc += 4;
        end
        redirect(1'b1, 32'h1c00_2000, 1'b1, 32'h1c00_3000);    // exception beats branch
        exp_pc = 32'h1c00_2000;
        repeat (3) begin
            expect_inst(exp_pc, exp_pc, '0);
            exp_pc += 4;
        end
    endtask

    task automatic test_dmw();
        csr_direct_addr = 1'b0;
        dmw0_plv0       = 1'b1;
        dmw0_vseg       = 3'b101;
        dmw0_pseg       = 3'b001;
        redirect(1'b0, 32'h0, 1'b1, 32'ha000_4000);
        exp_pc = 32'ha000_4000;
        repeat (3) begin
            expect_inst(exp_pc, {dmw0_pseg, exp_pc[28:0]}, '0);
            exp_pc += 4;
        end
        crmd_plv = plv_user;        // no window open at plv 3, tlb still empty
        expect_fault(32'h0000_2002, exc_bit(exc_adef) | exc_bit(exc_tlbr));
    endtask

    task automatic test_tlb();
        write_tlb(0, 20'h00010, ps_4k, 20'h12345, 2'd3, 1'b1);
        write_tlb(1, 20'h00400, ps_4m, 20'h0c000, 2'd3, 1'b1);
        write_tlb(2, 20'h00020, ps_4k, 20'h00abc, 2'd0, 1'b0);
        write_tlb(3, 20'h00030, ps_4k, 20'h00def, 2'd0, 1'b1);
        crmd_plv = 2'd0;
        redirect(1'b0, 32'h0, 1'b1, 32'h0001_0100);
        exp_pc = 32'h0001_0100;
        repeat (2) begin
            expect_inst(exp_pc, page_addr(exp_pc, 20'h12345, ps_4k), '0);
            exp_pc += 4;
        end
        redirect(1'b0, 32'h0, 1'b1, 32'h0041_2340);
        exp_pc = 32'h0041_2340;
        repeat (2) begin
            expect_inst(exp_pc, page_addr(exp_pc, 20'h0c000, ps_4m), '0);
            exp_pc += 4;
        end
        expect_fault(32'h0005_0000, exc_bit(exc_tlbr));    // unmapped page
        expect_fault(32'h0002_0000, exc_bit(exc_pif));
        crmd_plv = plv_user;
        expect_fault(32'h0003_0000, exc_bit(exc_ppi));     // plv 0 page
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        timed_out       = 1'b0;
        resetn          = 1'b0;
        ds_allowin      = 1'b1;
        wb_ex           = 1'b0;
        ertn_flush      = 1'b0;
        br_taken        = 1'b0;
        br_stall        = 1'b0;
        ex_entry        = '0;
        ertn_entry      = '0;
        br_target       = '0;
        crmd_plv        = 2'd0;
        csr_direct_addr = 1'b1;
        dmw0_plv0       = 1'b0;
        dmw0_plv3       = 1'b0;
        dmw1_plv0       = 1'b0;
        dmw1_plv3       = 1'b0;
        dmw0_vseg       = '0;
        dmw0_pseg       = '0;
        dmw1_vseg       = '0;
        dmw1_pseg       = '0;
        tlb_we          = 1'b0;
        tlb_w_index     = '0;
        tlb_w_e         = 1'b0;
        tlb_w_vppn      = '0;
        tlb_w_ps        = '0;
        tlb_w_ppn       = '0;
        tlb_w_plv       = '0;
        tlb_w_v         = 1'b0;

        repeat (9) begin
            @(negedge clk);
            #4;
            check("req during reset", 32'(inst_sram_req), 32'd0);
            check("valid during reset", 32'(fs2ds_valid), 32'd0);
        end
        @(negedge clk);
        resetn = 1'b1;

        test_sequential();
        if (!timed_out)
            test_backpressure();
        if (!timed_out)
            test_redirect();
        if (!timed_out)
            test_dmw();
        if (!timed_out)
            test_tlb();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* fetch_unit.f */
verilog/fetch_pkg.sv
verilog/itlb.sv
verilog/addr_translate.sv
verilog/fetch_stage.sv
verilog/fetch_unit.sv
tb/inst_sram_model.sv
tb/tb_fetch_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_fetch_unit -f fetch_unit.f \
    && ./obj_dir/Vtb_fetch_unit | tee /dev/stderr \
        | grep -F "Simulation finished: PASS" > /dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
